//--- src/lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// datapath word and address width
`define LC3B_WIDTH 16

// architectural register count
`define LC3B_NREGS 8

// first fetch address
`define LC3B_RESET_PC 16'h0000

// br with no nzp bits is never taken
`define LC3B_NOP 16'h0000

`endif

//--- src/lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;
    typedef logic [1:0]  lc3b_mem_wmask;

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_stb = 4'b0011,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;
        lc3b_reg    src1;
        logic       imm_flag;
        logic [4:0] imm5;     // src2 sits in the low three bits
    } lc3b_arith_view;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;     // nzp for br
        lc3b_reg    base;
        logic [5:0] offset6;  // br offset9 is {base, offset6}
    } lc3b_mem_view;

    typedef union packed {
        lc3b_word       word;
        lc3b_arith_view arith;
        lc3b_mem_view   mem;
    } lc3b_instr;

    typedef struct packed {
        lc3b_opcode    opcode;
        lc3b_aluop     aluop;
        logic [1:0]    imm_sel;         // 0 reg, 1 imm5, 2 offset6, 3 offset9
        logic          load_regfile;
        logic          load_cc;
        logic          mem_read;
        logic          mem_write;
        lc3b_mem_wmask mem_byte_enable;
        logic          is_branch;
        logic          regfile_sel;     // 1 picks the mdr
        lc3b_reg       dest;
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire

//--- src/control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom
    import lc3b_types::*;
(
    input  var lc3b_instr     instr,
    output lc3b_control_word  ctrl
);

    always_comb
    begin
        ctrl = '0;
        ctrl.opcode = instr.arith.opcode;
        ctrl.aluop = alu_pass;
        case (instr.arith.opcode)
            op_add, op_and, op_not:
            begin
                if (instr.arith.opcode == op_add)
                    ctrl.aluop = alu_add;
                else if (instr.arith.opcode == op_and)
                    ctrl.aluop = alu_and;
                else
                    ctrl.aluop = alu_not;
                ctrl.imm_sel = {1'b0, instr.arith.imm_flag};
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.dest = instr.arith.dest;
            end
            op_ldr:
            begin
                ctrl.aluop = alu_add;              // base plus scaled offset
                ctrl.imm_sel = 2'd2;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.mem_byte_enable = 2'b11;
                ctrl.regfile_sel = 1'b1;
                ctrl.dest = instr.mem.dest;
            end
            op_str, op_stb:
            begin
                ctrl.aluop = alu_add;
                ctrl.imm_sel = 2'd2;
                ctrl.mem_write = 1'b1;
                // stb lanes come from the address later on
                ctrl.mem_byte_enable = (instr.mem.opcode == op_str) ? 2'b11 : 2'b00;
                ctrl.dest = instr.mem.dest;        // store source register
            end
            op_br:
            begin
                ctrl.aluop = alu_add;              // pc plus offset9
                ctrl.imm_sel = 2'd3;
                ctrl.is_branch = 1'b1;
                ctrl.dest = instr.mem.dest;        // nzp mask
            end
            default: ;
        endcase
    end

endmodule : control_rom

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module regfile
    import lc3b_types::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          load,
    input  var lc3b_word in,
    input  var lc3b_reg  src_a,
    input  var lc3b_reg  src_b,
    input  var lc3b_reg  dest,
    output lc3b_word     reg_a,
    output lc3b_word     reg_b
);

    lc3b_word data [`LC3B_NREGS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `LC3B_NREGS; i++)
                data[i] <= '0;
        end
        else if (load)
            data[dest] <= in;
    end

    // writeback value seen by decode in the same cycle
    assign reg_a = (load && dest == src_a) ? in : data[src_a];
    assign reg_b = (load && dest == src_b) ? in : data[src_b];

    a_dest_known: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !$isunknown(dest));

endmodule : regfile

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import lc3b_types::*;
(
    input  var lc3b_aluop aluop,
    input  var lc3b_word  a,
    input  var lc3b_word  b,
    output lc3b_word      f
);

    always_comb
    begin
        case (aluop)
            alu_add:  f = a + b;
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            alu_pass: f = b;          // operand b straight through
            default:  f = b;
        endcase
    end

endmodule : alu

`default_nettype wire

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import lc3b_types::*;
(
    input  var lc3b_reg          dec_src1,
    input  var lc3b_reg          dec_src2,
    input  var lc3b_reg          exec_src1,
    input  var lc3b_reg          exec_src2,
    input  var lc3b_reg          mem_dest,
    input  var lc3b_reg          wb_dest,
    input  var lc3b_control_word exec_ctrl,
    input  var lc3b_control_word mem_ctrl,
    input  var lc3b_control_word wb_ctrl,
    input  wire                  branch_taken,
    output logic [1:0]           sel_a,
    output logic [1:0]           sel_b,
    output logic                 bubble,
    output logic                 flush
);

    logic mem_fwd;
    logic wb_fwd;

    // loads in memory have no data yet
    assign mem_fwd = mem_ctrl.load_regfile && !mem_ctrl.mem_read;
    assign wb_fwd  = wb_ctrl.load_regfile;

    // younger result wins
    always_comb
    begin
        sel_a = 2'b00;                     // regfile value
        if (mem_fwd && mem_dest == exec_src1)
            sel_a = 2'b01;
        else if (wb_fwd && wb_dest == exec_src1)
            sel_a = 2'b10;

        sel_b = 2'b00;
        if (mem_fwd && mem_dest == exec_src2)
            sel_b = 2'b01;
        else if (wb_fwd && wb_dest == exec_src2)
            sel_b = 2'b10;
    end

    // load in execute feeding the instruction in decode
    assign bubble = exec_ctrl.mem_read &&
                    (exec_ctrl.dest == dec_src1 || exec_ctrl.dest == dec_src2);

    assign flush = branch_taken;           // kills exec, decode and fetch

endmodule : hazard_unit

`default_nettype wire

//--- src/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module datapath
    import lc3b_types::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           i_mem_resp,
    input  wire           d_mem_resp,
    input  var lc3b_word  instr_rdata,
    input  var lc3b_word  mem_rdata,
    output logic          instr_read,
    output lc3b_word      instr_address,
    output logic          mem_read,
    output logic          mem_write,
    output lc3b_word      mem_address,
    output lc3b_word      mem_wdata,
    output lc3b_mem_wmask mem_byte_enable
);

    logic global_load;
    logic bubble;
    logic flush;
    logic branch_taken;
    logic [1:0] sel_a;
    logic [1:0] sel_b;

    lc3b_instr ir;
    lc3b_word dec_pc;
    lc3b_control_word ctrl_dec;
    lc3b_reg dec_src2;
    lc3b_word reg_a;
    lc3b_word reg_b;

    lc3b_instr exec_ir;
    lc3b_word exec_pc;
    lc3b_control_word ctrl_exec;
    lc3b_reg exec_src1;
    lc3b_reg exec_src2;
    lc3b_word exec_a;
    lc3b_word exec_b;
    lc3b_word fwd_a;
    lc3b_word fwd_b;
    lc3b_word alu_a;
    lc3b_word alu_b;
    lc3b_word off6;
    lc3b_word alu_out;

    lc3b_control_word ctrl_mem;
    lc3b_word mem_store;

    lc3b_control_word ctrl_wb;
    lc3b_word wb_result;
    lc3b_word mdr;
    lc3b_word wb_value;
    lc3b_nzp cc;
    lc3b_nzp wb_cc;
    lc3b_nzp flags;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            instr_read <= 1'b0;
        else
            instr_read <= 1'b1;            // fetch never idles
    end

    // fetch and decode
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            instr_address <= `LC3B_RESET_PC;
            ir <= `LC3B_NOP;
        end
        else if (global_load)
        begin
            if (flush)
            begin
                instr_address <= mem_address;   // target computed in execute
                ir <= `LC3B_NOP;
            end
            else if (!bubble)
            begin
                instr_address <= instr_address + 16'd2;
                ir <= instr_rdata;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (global_load && !bubble)
            dec_pc <= instr_address + 16'd2;
        if (global_load)
        begin
            exec_ir <= ir;
            exec_pc <= dec_pc;
            exec_src1 <= ir.arith.src1;
            exec_src2 <= dec_src2;
            exec_a <= reg_a;
            exec_b <= reg_b;
            mem_address <= alu_out;
            mem_store <= fwd_b;
            wb_result <= mem_address;
        end
        if (global_load && ctrl_mem.mem_read)
            mdr <= mem_rdata;
    end

    // control words down the pipe
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctrl_exec <= '0;
            ctrl_mem <= '0;
            ctrl_wb <= '0;
            cc <= 3'b010;
        end
        else if (global_load)
        begin
            if (flush || bubble)
                ctrl_exec <= '0;
            else
                ctrl_exec <= ctrl_dec;
            if (flush)
                ctrl_mem <= '0;
            else
                ctrl_mem <= ctrl_exec;
            ctrl_wb <= ctrl_mem;
            if (ctrl_wb.load_cc)
                cc <= wb_cc;
        end
    end

    assign dec_src2 = ctrl_dec.mem_write ? ctrl_dec.dest : ir.arith.imm5[2:0];

    // operand muxes in execute
    always_comb
    begin
        fwd_a = (sel_a == 2'b01) ? mem_address : (sel_a == 2'b10) ? wb_value : exec_a;
        fwd_b = (sel_b == 2'b01) ? mem_address : (sel_b == 2'b10) ? wb_value : exec_b;
        alu_a = ctrl_exec.is_branch ? exec_pc : fwd_a;
        off6 = {{(`LC3B_WIDTH-6){exec_ir.mem.offset6[5]}}, exec_ir.mem.offset6};
        if (ctrl_exec.opcode != op_stb)
            off6 = {off6[14:0], 1'b0};    // word offset
        case (ctrl_exec.imm_sel)
            2'd0: alu_b = fwd_b;
            2'd1: alu_b = {{(`LC3B_WIDTH-5){exec_ir.arith.imm5[4]}}, exec_ir.arith.imm5};
            2'd2: alu_b = off6;
            default: alu_b = {{(`LC3B_WIDTH-10){exec_ir.mem.base[2]}}, exec_ir.mem.base,
                              exec_ir.mem.offset6, 1'b0};
        endcase
    end

    // writeback value, flags and branch resolution
    always_comb
    begin
        wb_value = ctrl_wb.regfile_sel ? mdr : wb_result;
        if (wb_value[15])
            wb_cc = 3'b100;
        else if (wb_value == '0)
            wb_cc = 3'b010;
        else
            wb_cc = 3'b001;
        flags = ctrl_wb.load_cc ? wb_cc : cc;   // previous instruction not yet in cc
        branch_taken = ctrl_mem.is_branch && |(ctrl_mem.dest & flags);
    end

    assign mem_read = ctrl_mem.mem_read;
    assign mem_write = ctrl_mem.mem_write;
    assign mem_byte_enable = (ctrl_mem.opcode == op_stb) ?
                             (mem_address[0] ? 2'b10 : 2'b01) : ctrl_mem.mem_byte_enable;
    assign mem_wdata = (ctrl_mem.opcode == op_stb) ?
                       {mem_store[7:0], mem_store[7:0]} : mem_store;
    // hold everything while a memory is still busy
    assign global_load = i_mem_resp && (d_mem_resp || !(mem_read || mem_write));

    control_rom control_rom_module (.instr(ir), .ctrl(ctrl_dec));

    regfile regfile_module
    (
        .clk(clk),
        .rst_n(rst_n),
        .load(ctrl_wb.load_regfile && global_load),
        .in(wb_value),
        .src_a(ir.arith.src1),
        .src_b(dec_src2),
        .dest(ctrl_wb.dest),
        .reg_a(reg_a),
        .reg_b(reg_b)
    );

    alu alu_module (.aluop(ctrl_exec.aluop), .a(alu_a), .b(alu_b), .f(alu_out));

    hazard_unit hazard_module
    (
        .dec_src1(ir.arith.src1),
        .dec_src2(dec_src2),
        .exec_src1(exec_src1),
        .exec_src2(exec_src2),
        .mem_dest(ctrl_mem.dest),
        .wb_dest(ctrl_wb.dest),
        .exec_ctrl(ctrl_exec),
        .mem_ctrl(ctrl_mem),
        .wb_ctrl(ctrl_wb),
        .branch_taken(branch_taken),
        .sel_a(sel_a),
        .sel_b(sel_b),
        .bubble(bubble),
        .flush(flush)
    );

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write));
    a_write_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write |-> mem_byte_enable != 2'b00);

endmodule : datapath

`default_nettype wire

//--- sim/tb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_datapath
    import lc3b_types::*;
;

    logic          clk = 1'b0;
    logic          rst_n = 1'b0;
    logic          i_mem_resp = 1'b0;
    logic          d_mem_resp = 1'b0;
    lc3b_word      instr_rdata = '0;
    lc3b_word      mem_rdata = '0;
    logic          instr_read;
    lc3b_word      instr_address;
    logic          mem_read;
    logic          mem_write;
    lc3b_word      mem_address;
    lc3b_word      mem_wdata;
    lc3b_mem_wmask mem_byte_enable;

    lc3b_word      imem [256];
    lc3b_word      dmem [256];
    lc3b_word      dmem_init [256];
    lc3b_word      exp_addr [64];
    lc3b_word      exp_data [64];
    lc3b_mem_wmask exp_mask [64];
    int            seg_end [8];
    int            seg_id [8];
    int            nprog = 0;
    int            nexp = 0;
    int            nseg = 0;
    int            seen = 0;
    int            seg = 0;
    int            err_count = 0;
    int            err_base = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            cycles = 0;
    int            phase_start = 0;
    int            limit = 1000;
    int            wait_cnt = 0;
    logic          random_mode = 1'b0;
    logic          holding = 1'b0;
    logic [31:0]   seed = 32'h8c34;
    logic [51:0]   held_req = '0;
    logic [51:0]   req_bits;

    always #10 clk = ~clk;

    datapath DUT
    (
        .clk(clk),
        .rst_n(rst_n),
        .i_mem_resp(i_mem_resp),
        .d_mem_resp(d_mem_resp),
        .instr_rdata(instr_rdata),
        .mem_rdata(mem_rdata),
        .instr_read(instr_read),
        .instr_address(instr_address),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_byte_enable(mem_byte_enable)
    );

    // everything a pending request must hold steady
    assign req_bits = {instr_address, mem_read, mem_write, mem_address, mem_wdata,
                       mem_byte_enable};

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        if (got !== exp)
        begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_mask(input string name, input lc3b_mem_wmask got,
                              input lc3b_mem_wmask exp);
        if (got !== exp)
        begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input int id);
        tests_run++;
        if (err_count == err_base)
            $display("test %0d passed", id);
        else
        begin
            $display("test %0d failed with %0d errors", id, err_count - err_base);
            tests_failed++;
        end
        err_base = err_count;
    endtask

    task automatic check_store;
        if (seen >= nexp)
        begin
            $display("unexpected store to address %h after all %0d expected stores",
                     mem_address, nexp);
            err_count++;
        end
        else
        begin
            check_word("mem_address", mem_address, exp_addr[seen]);
            check_word("mem_wdata", mem_wdata, exp_data[seen]);
            check_mask("mem_byte_enable", mem_byte_enable, exp_mask[seen]);
            seen++;
            if (!random_mode && seg < nseg && seen == seg_end[seg])
            begin
                report_test(seg_id[seg]);
                seg++;
            end
        end
    endtask

    // one responder for both memories so the i and d strobes land together
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            i_mem_resp <= 1'b0;
            d_mem_resp <= 1'b0;
            wait_cnt <= 0;
            holding <= 1'b0;
        end
        else if (i_mem_resp)
        begin
            i_mem_resp <= 1'b0;
            d_mem_resp <= 1'b0;
            holding <= 1'b0;
            seed = lcg_next(seed);
            wait_cnt <= random_mode ? int'((seed >> 16) % 3) : 0;
        end
        else if (instr_read)
        begin
            if (holding && req_bits !== held_req)
            begin
                $display("request changed while waiting: %h became %h", held_req, req_bits);
                err_count++;
            end
            held_req <= req_bits;
            holding <= 1'b1;
            if (wait_cnt == 0)
            begin
                i_mem_resp <= 1'b1;
                instr_rdata <= imem[instr_address[8:1]];
                if (mem_read)
                begin
                    d_mem_resp <= 1'b1;
                    mem_rdata <= dmem[mem_address[8:1]];
                end
                if (mem_write)
                begin
                    d_mem_resp <= 1'b1;
                    if (mem_byte_enable[0])
                        dmem[mem_address[8:1]][7:0] <= mem_wdata[7:0];
                    if (mem_byte_enable[1])
                        dmem[mem_address[8:1]][15:8] <= mem_wdata[15:8];
                    check_store();
                end
            end
            else
                wait_cnt <= wait_cnt - 1;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles - phase_start >= limit)
        begin
            $display("timeout: only %0d of %0d expected stores seen", seen, nexp);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic load_trace;
        int fd;
        int r;
        int i;
        logic [7:0] tag;
        logic [15:0] a;
        logic [15:0] w;
        logic [15:0] d;
        logic [8*120-1:0] line;
        logic done;
        for (i = 0; i < 256; i++)
        begin
            imem[i] = {7'b0, i[7:0], 1'b1};     // never-taken br
            dmem_init[i] = {~i[7:0], i[7:0]};
        end
        fd = $fopen("sim/datapath_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file");
            err_count++;
            return;
        end
        done = 1'b0;
        while (!done)
        begin
            r = $fscanf(fd, " %c", tag);
            if (r != 1)
                done = 1'b1;
            else if (tag == "#")
                r = $fgets(line, fd);
            else if (tag == "P")
            begin
                r = $fscanf(fd, "%h", a);
                for (i = 0; i < 8; i++)
                begin
                    r = $fscanf(fd, "%h", w);
                    imem[a[8:1] + i] = w;
                    nprog++;
                end
            end
            else if (tag == "D")
            begin
                r = $fscanf(fd, "%h %h", a, w);
                dmem_init[a[8:1]] = w;
            end
            else if (tag == "W")
            begin
                r = $fscanf(fd, "%h %h %h", a, w, d);
                exp_addr[nexp] = a;
                exp_data[nexp] = w;
                exp_mask[nexp] = d[1:0];
                nexp++;
            end
            else if (tag == "T")
            begin
                r = $fscanf(fd, "%d", i);
                seg_id[nseg] = i;
                seg_end[nseg] = nexp;
                nseg++;
            end
            else
                done = 1'b1;                    // E line
        end
        $fclose(fd);
    endtask

    task automatic run_phase(input logic rand_delays);
        int i;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        random_mode = rand_delays;
        for (i = 0; i < 256; i++)
            dmem[i] = dmem_init[i];
        seen = 0;
        seg = 0;
        phase_start = cycles;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        while (seen < nexp)
            @(posedge clk);
        repeat (20) @(posedge clk);           // room for stray stores
    endtask

    initial
    begin
        load_trace();
        limit = 8 * (nprog + nexp) + 200;
        run_phase(1'b0);
        run_phase(1'b1);
        report_test(5);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule : tb_datapath

`default_nettype wire

//--- sim/datapath_trace.txt
# P byte_addr then 8 program words, D byte_addr data, W byte_addr data mask
# T test id closes a group of W lines, E ends the file
P 0000 1227 147D 5681 98FF 1B02 7A00 7601 533E
P 0010 7202 6410 16A5 7603 6811 1B03 7A04 5DA0
P 0020 0403 720A 720B 720C 1DA9 0801 7C05 0201
P 0030 7C06 7C07 1E33 3E10 3E11 3C13 6408 740D
D 0020 1234
D 0022 0FF0
W 0000 FFFF 3
W 0002 0004 3
W 0004 FFFA 3
T 1
W 0006 1239 3
W 0008 2229 3
T 2
W 000A 0009 3
W 000E 0009 3
T 3
W 0010 F3F3 1
W 0011 F3F3 2
W 0013 0909 2
W 001A F3F3 3
T 4
E

//--- list.f
+incdir+src
src/lc3b_types.sv
src/control_rom.sv
src/regfile.sv
src/alu.sv
src/hazard_unit.sv
src/datapath.sv
sim/tb_datapath.sv
